// ==== sim.f ====
src_pkg.sv
step_counter.sv
control_fsm.sv
register_file.sv
alu_unit.sv
bus_datapath.sv
src_top.sv
tb_src_top.sv

// ==== tb_src_top.sv ====
`timescale 1ns/1ps

module tb_src_top import src_pkg::*; ();

	localparam int CLK_PERIOD = 100;
	localparam int RESET_CYCLES = 16;
	localparam int NUM_INSTR = 400;
	localparam int ACK_LIMIT = 20;
	localparam int ACK_LATENCY = 5;
	localparam int WATCHDOG_CYCLES = NUM_INSTR * 12 + RESET_CYCLES;

	logic clk;
	logic rst;
	instr_u instr;
	logic req;
	logic ack;
	logic [DATA_W-1:0] out_data;

	integer seed;
	int errors;
	int i;
	instr_u w;
	logic [REG_AW-1:0] last_ra;

	// architectural state as seen by the host
	logic [DATA_W-1:0] model_regs [REG_N];
	logic [DATA_W-1:0] model_out;

	src_top DUT (
		.clk(clk),
		.rst(rst),
		.instr(instr),
		.req(req),
		.ack(ack),
		.out_data(out_data)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		errors++;
		$display("Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
		$display("ERRORS FOUND");
		$fatal(1, "value check failed");
	endtask

	task automatic report_failure(input string what);
		errors++;
		$display("Failure at %0t ns: %s", $time, what);
		$display("ERRORS FOUND");
		$fatal(1, "check failed");
	endtask

	function automatic logic [31:0] sign_extend(input logic [IMM_W-1:0] imm);
		logic [31:0] c;
		c = 32'(imm);
		if (imm[IMM_W-1]) begin
			c = c | ~((32'd1 << IMM_W) - 32'd1);
		end
		return c;
	endfunction

	function automatic bit is_known_op(input logic [4:0] code);
		case (code)
			5'b00001, 5'b00011, 5'b00100, 5'b00101, 5'b00110, 5'b01100, 5'b10111: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	task automatic random_instr(output instr_u word);
		int r;
		logic [4:0] code;
		word = $random(seed);
		r = $random(seed) & 15;
		case (r)
			0: begin
				// rare illegal code
				code = $random(seed) & 31;
				while (is_known_op(code)) begin
					code = $random(seed) & 31;
				end
				word.imm_fmt.opcode = opcode_e'(code);
			end
			1, 2: begin
				word.imm_fmt.opcode = OP_LDI;
				if (r == 1) begin
					word.imm_fmt.rb = '0;
				end
			end
			3, 4: word.imm_fmt.opcode = OP_ADDI;
			5, 6: word.imm_fmt.opcode = OP_ADD;
			7, 8: word.imm_fmt.opcode = OP_SUB;
			9, 10: word.imm_fmt.opcode = OP_AND;
			11, 12: word.imm_fmt.opcode = OP_OR;
			13: word.imm_fmt.opcode = OP_OUT;
			default: word.imm_fmt.opcode = OP_ADDI;
		endcase
	endtask

	task automatic out_instr(input logic [REG_AW-1:0] ra, output instr_u word);
		word = $random(seed);
		word.imm_fmt.opcode = OP_OUT;
		word.imm_fmt.ra = ra;
	endtask

	task automatic apply_model(input instr_u word);
		logic [REG_AW-1:0] ra;
		logic [REG_AW-1:0] rb;
		logic [REG_AW-1:0] rc;
		logic [31:0] c;
		ra = word.imm_fmt.ra;
		rb = word.imm_fmt.rb;
		rc = word.reg_fmt.rc;
		c = sign_extend(word.imm_fmt.imm);
		case (word.imm_fmt.opcode)
			OP_LDI: model_regs[ra] = (rb == 0) ? c : model_regs[rb] + c;
			OP_ADDI: model_regs[ra] = model_regs[rb] + c;
			OP_ADD: model_regs[ra] = model_regs[rb] + model_regs[rc];
			OP_SUB: model_regs[ra] = model_regs[rb] - model_regs[rc];
			OP_AND: model_regs[ra] = model_regs[rb] & model_regs[rc];
			OP_OR: model_regs[ra] = model_regs[rb] | model_regs[rc];
			OP_OUT: model_out = model_regs[ra];
			default: begin
			end
		endcase
	endtask

	// one four-phase transfer, starting on a falling edge with the DUT idle
	task automatic handshake(input instr_u word);
		int edges;
		int hold;
		instr = word;
		req = 1'b1;
		edges = 0;
		while (ack !== 1'b1 && edges < ACK_LIMIT) begin
			@(negedge clk);
			edges++;
		end
		assert (ack === 1'b1)
			else report_failure("ack never rose after req was raised");
		// first edge after raising req is the capture edge
		assert (edges - 1 == ACK_LATENCY)
			else report_mismatch("ack latency", 32'(edges - 1), 32'(ACK_LATENCY));
		assert (out_data === model_out)
			else report_mismatch("out_data", out_data, model_out);
		hold = $random(seed) & 3;
		repeat (hold) begin
			@(negedge clk);
			assert (ack === 1'b1)
				else report_mismatch("ack", 32'(ack), 32'd1);
		end
		req = 1'b0;
		@(negedge clk);
		assert (ack === 1'b0)
			else report_mismatch("ack", 32'(ack), 32'd0);
		// ack low gap before the next request
		@(negedge clk);
		assert (out_data === model_out)
			else report_mismatch("out_data", out_data, model_out);
	endtask

	initial begin
		rst = 1'b1;
		req = 1'b0;
		instr = '0;
		seed = 34;
		errors = 0;
		last_ra = '0;
		model_out = '0;
		for (int k = 0; k < REG_N; k++) begin
			model_regs[k] = '0;
		end
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		@(negedge clk);
		assert (ack === 1'b0)
			else report_mismatch("ack", 32'(ack), 32'd0);
		assert (out_data === '0)
			else report_mismatch("out_data", out_data, 32'd0);
		// an out every fourth slot shows what the last writes did
		for (i = 0; i < NUM_INSTR; i++) begin
			if (i % 4 == 0) begin
				if (i == 0) begin
					last_ra = $random(seed);
				end
				out_instr(last_ra, w);
			end else begin
				random_instr(w);
				last_ra = w.imm_fmt.ra;
			end
			apply_model(w);
			handshake(w);
		end
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Timeout: run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
		$display("ERRORS FOUND");
		$fatal(1, "watchdog expired");
	end

endmodule

// ==== src_top.sv ====
`timescale 1ns/1ps

module src_top import src_pkg::*; (
	input logic clk,
	input logic rst,
	input instr_u instr,
	input logic req,
	output logic ack,
	output logic [DATA_W-1:0] out_data
);

	ctrl_s ctrl;
	opcode_e opcode;
	logic [STEP_W-1:0] step;
	logic step_clear;
	logic step_advance;

	control_fsm u_control_fsm (
		.clk(clk),
		.rst(rst),
		.req(req),
		.ack(ack),
		.opcode(opcode),
		.step(step),
		.step_clear(step_clear),
		.step_advance(step_advance),
		.ctrl(ctrl)
	);

	step_counter u_step_counter (
		.clk(clk),
		.rst(rst),
		.step_clear(step_clear),
		.step_advance(step_advance),
		.step(step)
	);

	bus_datapath u_bus_datapath (
		.clk(clk),
		.rst(rst),
		.instr(instr),
		.ctrl(ctrl),
		.opcode(opcode),
		.out_data(out_data)
	);

endmodule

// ==== bus_datapath.sv ====
`timescale 1ns/1ps

module bus_datapath import src_pkg::*; (
	input logic clk,
	input logic rst,
	input instr_u instr,
	input ctrl_s ctrl,
	output opcode_e opcode,
	output logic [DATA_W-1:0] out_data
);

	instr_u ir;
	logic [DATA_W-1:0] bus;
	logic [DATA_W-1:0] rdata;
	logic [DATA_W-1:0] z;
	logic [DATA_W-1:0] c_ext;

	always_ff @(posedge clk) begin
		if (rst) begin
			ir <= '0;
		end else if (ctrl.ir_in) begin
			ir <= instr;
		end
	end

	assign opcode = ir.imm_fmt.opcode;

	// single shared bus, zero when nothing drives it
	always_comb begin
		case (ctrl.bus_src)
			BUS_REG: bus = rdata;
			BUS_Z: bus = z;
			BUS_C: bus = c_ext;
			default: bus = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			out_data <= '0;
		end else if (ctrl.out_in) begin
			out_data <= bus;
		end
	end

	register_file u_register_file (
		.clk(clk),
		.rst(rst),
		.ir(ir),
		.reg_sel(ctrl.reg_sel),
		.base_out(ctrl.base_out),
		.reg_in(ctrl.reg_in),
		.wdata(bus),
		.rdata(rdata)
	);

	alu_unit u_alu_unit (
		.clk(clk),
		.rst(rst),
		.bus(bus),
		.ir(ir),
		.y_in(ctrl.y_in),
		.z_in(ctrl.z_in),
		.alu_op(ctrl.alu_op),
		.z(z),
		.c_ext(c_ext)
	);

	assert property (@(posedge clk) disable iff (rst)
		ctrl.ir_in |-> !ctrl.reg_in)
		else $error("instruction register loaded during write-back");

endmodule

// ==== alu_unit.sv ====
`timescale 1ns/1ps

module alu_unit import src_pkg::*; (
	input logic clk,
	input logic rst,
	input logic [DATA_W-1:0] bus,
	input instr_u ir,
	input logic y_in,
	input logic z_in,
	input opcode_e alu_op,
	output logic [DATA_W-1:0] z,
	output logic [DATA_W-1:0] c_ext
);

	logic [DATA_W-1:0] y;
	logic [DATA_W-1:0] result;

	// constant sign-extended from the immediate view
	assign c_ext = {{(DATA_W-IMM_W){ir.imm_fmt.imm[IMM_W-1]}}, ir.imm_fmt.imm};

	// second operand always comes in over the bus
	always_comb begin
		case (alu_op)
			OP_LDI, OP_ADDI, OP_ADD: result = y + bus;
			OP_SUB: result = y - bus;
			OP_AND: result = y & bus;
			OP_OR: result = y | bus;
			default: result = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			y <= '0;
		end else if (y_in) begin
			y <= bus;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			z <= '0;
		end else if (z_in) begin
			z <= result;
		end
	end

	// z is computed from y loaded in the step before
	assert property (@(posedge clk) disable iff (rst)
		z_in |-> $past(y_in))
		else $error("z loaded without a fresh y operand");

endmodule

// ==== register_file.sv ====
`timescale 1ns/1ps

module register_file import src_pkg::*; (
	input logic clk,
	input logic rst,
	input instr_u ir,
	input reg_sel_e reg_sel,
	input logic base_out,
	input logic reg_in,
	input logic [DATA_W-1:0] wdata,
	output logic [DATA_W-1:0] rdata
);

	logic [DATA_W-1:0] regs [REG_N];
	logic [REG_AW-1:0] rd_idx;

	// read index from the field picked by the control step
	always_comb begin
		case (reg_sel)
			SEL_RA: rd_idx = ir.reg_fmt.ra;
			SEL_RB: rd_idx = ir.reg_fmt.rb;
			SEL_RC: rd_idx = ir.reg_fmt.rc;
			default: rd_idx = ir.reg_fmt.ra;
		endcase
	end

	// base_out turns r0 into a zero base for ldi
	always_comb begin
		if (base_out && rd_idx == '0) begin
			rdata = '0;
		end else begin
			rdata = regs[rd_idx];
		end
	end

	// writes always land in ra, r0 included
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < REG_N; i++) begin
				regs[i] <= '0;
			end
		end else if (reg_in) begin
			regs[ir.imm_fmt.ra] <= wdata;
		end
	end

	// write-back only ever happens with ra selected on the bus path
	assert property (@(posedge clk) disable iff (rst)
		reg_in |-> reg_sel == SEL_RA)
		else $error("register write with select %s", reg_sel.name());

endmodule

// ==== control_fsm.sv ====
`timescale 1ns/1ps

module control_fsm import src_pkg::*; (
	input logic clk,
	input logic rst,
	input logic req,
	output logic ack,
	input opcode_e opcode,
	input logic [STEP_W-1:0] step,
	output logic step_clear,
	output logic step_advance,
	output ctrl_s ctrl
);

	typedef enum logic [1:0] {
		IDLE,
		EXEC,
		DONE,
		WAIT_LOW
	} state_e;

	state_e state;
	state_e state_next;
	logic ack_next;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
			ack <= 1'b0;
		end else begin
			state <= state_next;
			ack <= ack_next;
		end
	end

	// ack comes up one edge into done and drops as soon as req is seen low
	assign ack_next = (state == DONE) && req;

	always_comb begin
		state_next = state;
		step_clear = 1'b0;
		step_advance = 1'b0;
		ctrl = '0;
		ctrl.alu_op = opcode;
		case (state)
			IDLE: begin
				if (req) begin
					ctrl.ir_in = 1'b1;
					step_clear = 1'b1;
					state_next = EXEC;
				end
			end
			EXEC: begin
				if (step == STEP_LAST) begin
					state_next = DONE;
				end else begin
					step_advance = 1'b1;
				end
				case (opcode)
					OP_LDI, OP_ADDI, OP_ADD, OP_SUB, OP_AND, OP_OR: begin
						case (step)
							3'd1: begin
								// rb into y, ldi reads r0 as zero
								ctrl.bus_src = BUS_REG;
								ctrl.reg_sel = SEL_RB;
								ctrl.base_out = (opcode == OP_LDI);
								ctrl.y_in = 1'b1;
							end
							3'd2: begin
								ctrl.z_in = 1'b1;
								if (opcode == OP_LDI || opcode == OP_ADDI) begin
									ctrl.bus_src = BUS_C;
								end else begin
									ctrl.bus_src = BUS_REG;
									ctrl.reg_sel = SEL_RC;
								end
							end
							3'd3: begin
								// write back z to ra
								ctrl.bus_src = BUS_Z;
								ctrl.reg_sel = SEL_RA;
								ctrl.reg_in = 1'b1;
							end
							default: begin
							end
						endcase
					end
					OP_OUT: begin
						if (step == 3'd1) begin
							ctrl.bus_src = BUS_REG;
							ctrl.reg_sel = SEL_RA;
							ctrl.out_in = 1'b1;
						end
					end
					// unknown codes just run out the steps
					default: begin
					end
				endcase
			end
			DONE: begin
				if (!req) begin
					state_next = WAIT_LOW;
				end
			end
			WAIT_LOW: begin
				// one quiet cycle with ack low before the next req
				state_next = IDLE;
			end
			default: begin
				state_next = IDLE;
			end
		endcase
	end

	assert property (@(posedge clk) disable iff (rst)
		state == IDLE |-> !ack)
		else $error("ack high while idle");

	assert property (@(posedge clk) disable iff (rst)
		!(ctrl.reg_in && ctrl.out_in))
		else $error("register write and output load in the same step");

endmodule

// ==== step_counter.sv ====
`timescale 1ns/1ps

module step_counter import src_pkg::*; (
	input logic clk,
	input logic rst,
	input logic step_clear,
	input logic step_advance,
	output logic [STEP_W-1:0] step
);

	// clear takes priority over advance
	always_ff @(posedge clk) begin
		if (rst) begin
			step <= '0;
		end else if (step_clear) begin
			step <= STEP_FIRST;
		end else if (step_advance) begin
			step <= step + 1'b1;
		end
	end

	// the fsm leaves exec on the last step instead of advancing
	assert property (@(posedge clk) disable iff (rst)
		step_advance && !step_clear |-> step < STEP_LAST)
		else $error("step counter advanced past step %0d", STEP_LAST);

	assert property (@(posedge clk) disable iff (rst)
		step <= STEP_LAST)
		else $error("step index %0d out of range", step);

endmodule

// ==== src_pkg.sv ====
package src_pkg;

	// word and register file sizes, fixed by the instruction format
	localparam int DATA_W = 32;
	localparam int REG_N = 16;
	localparam int REG_AW = 4;
	localparam int IMM_W = 19;

	// control step index
	localparam int STEP_W = 3;
	localparam logic [STEP_W-1:0] STEP_FIRST = 3'd1;
	localparam logic [STEP_W-1:0] STEP_LAST = 3'd4;

	typedef enum logic [4:0] {
		OP_LDI = 5'b00001,
		OP_ADD = 5'b00011,
		OP_SUB = 5'b00100,
		OP_AND = 5'b00101,
		OP_OR = 5'b00110,
		OP_ADDI = 5'b01100,
		OP_OUT = 5'b10111
	} opcode_e;

	// opcode, ra and rb line up in both views
	typedef struct packed {
		opcode_e opcode;
		logic [REG_AW-1:0] ra;
		logic [REG_AW-1:0] rb;
		logic [IMM_W-1:0] imm;
	} imm_fmt_s;

	typedef struct packed {
		opcode_e opcode;
		logic [REG_AW-1:0] ra;
		logic [REG_AW-1:0] rb;
		logic [REG_AW-1:0] rc;
		logic [IMM_W-REG_AW-1:0] unused;
	} reg_fmt_s;

	typedef union packed {
		imm_fmt_s imm_fmt;
		reg_fmt_s reg_fmt;
	} instr_u;

	typedef enum logic [1:0] {
		BUS_NONE = 2'd0,
		BUS_REG = 2'd1,
		BUS_Z = 2'd2,
		BUS_C = 2'd3
	} bus_src_e;

	typedef enum logic [1:0] {
		SEL_RA = 2'd0,
		SEL_RB = 2'd1,
		SEL_RC = 2'd2
	} reg_sel_e;

	// one control step worth of strobes
	typedef struct packed {
		bus_src_e bus_src;
		reg_sel_e reg_sel;
		logic base_out;
		logic reg_in;
		logic y_in;
		logic z_in;
		logic ir_in;
		logic out_in;
		opcode_e alu_op;
	} ctrl_s;

endpackage
